//--- thumb_pkg.sv
package thumb_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int WORD_SIZE  = 16;
  localparam int NUM_REG    = 16;
  localparam int REG_ID_W   = 4;
  localparam int ROM_ADDR_W = 10;

  // fixed register ids
  localparam logic [REG_ID_W-1:0] SP_ID = 4'd13;
  localparam logic [REG_ID_W-1:0] LR_ID = 4'd14;

  // control field widths
  localparam int OPCODE_W = 4;
  localparam int FU_W     = 2;
  localparam int SEL_W    = 2;
  localparam int S2_SEL_W = 3;

  // wr_en, illegal, opcode, fu, set_flags, dst sel, s1 sel, s2 sel
  localparam int UCODE_W = 2 + OPCODE_W + FU_W + 1 + 2 * SEL_W + S2_SEL_W;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ROM field encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // opcodes
  localparam logic [OPCODE_W-1:0] OP_ADD = 4'd0;
  localparam logic [OPCODE_W-1:0] OP_SUB = 4'd1;
  localparam logic [OPCODE_W-1:0] OP_MOV = 4'd2;
  localparam logic [OPCODE_W-1:0] OP_CMP = 4'd3;
  localparam logic [OPCODE_W-1:0] OP_AND = 4'd4;
  localparam logic [OPCODE_W-1:0] OP_ORR = 4'd5;
  localparam logic [OPCODE_W-1:0] OP_EOR = 4'd6;
  localparam logic [OPCODE_W-1:0] OP_LSL = 4'd7;
  localparam logic [OPCODE_W-1:0] OP_LSR = 4'd8;
  localparam logic [OPCODE_W-1:0] OP_LDR = 4'd9;
  localparam logic [OPCODE_W-1:0] OP_STR = 4'd10;
  localparam logic [OPCODE_W-1:0] OP_B   = 4'd11;

  // function units
  localparam logic [FU_W-1:0] FU_ALU    = 2'd0;
  localparam logic [FU_W-1:0] FU_SHIFT  = 2'd1;
  localparam logic [FU_W-1:0] FU_LSU    = 2'd2;
  localparam logic [FU_W-1:0] FU_BRANCH = 2'd3;

  // destination id select
  localparam logic [SEL_W-1:0] DST_LO0 = 2'd0;
  localparam logic [SEL_W-1:0] DST_HI8 = 2'd1;
  localparam logic [SEL_W-1:0] DST_SP  = 2'd2;
  localparam logic [SEL_W-1:0] DST_LR  = 2'd3;

  // source 1 id select
  localparam logic [SEL_W-1:0] S1_LO3 = 2'd0;
  localparam logic [SEL_W-1:0] S1_LO0 = 2'd1;
  localparam logic [SEL_W-1:0] S1_SP  = 2'd2;
  localparam logic [SEL_W-1:0] S1_LR  = 2'd3;

  // source 2 select, one code per extension candidate
  localparam logic [S2_SEL_W-1:0] S2_IMM8Z  = 3'd0;
  localparam logic [S2_SEL_W-1:0] S2_IMM3Z  = 3'd1;
  localparam logic [S2_SEL_W-1:0] S2_IMM7Z  = 3'd2;
  localparam logic [S2_SEL_W-1:0] S2_IMM5Z  = 3'd3;
  localparam logic [S2_SEL_W-1:0] S2_IMM8S  = 3'd4;
  localparam logic [S2_SEL_W-1:0] S2_IMM11S = 3'd5;
  localparam logic [S2_SEL_W-1:0] S2_IMM6S  = 3'd6;
  // register named by bits 6..3
  localparam logic [S2_SEL_W-1:0] S2_REG4   = 3'd7;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction halfword, two views
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef union packed {
    // immediate formats
    struct packed {
      logic [4:0] major;
      logic [2:0] rd_hi;
      logic [7:0] imm8;
    } imm;
    // three-register formats
    struct packed {
      logic [6:0] op;
      logic [2:0] rm;
      logic [2:0] rn;
      logic [2:0] rd;
    } regs;
  } thumb_inst_u;

endpackage

//--- microcode_rom.sv
`timescale 1ns/1ps

module microcode_rom
  import thumb_pkg::*;
  ( input  logic [ROM_ADDR_W-1:0] addr_i
  , output logic                  wr_en_o
  , output logic                  illegal_o
  , output logic [OPCODE_W-1:0]   opcode_o
  , output logic [FU_W-1:0]       func_unit_o
  , output logic                  set_flags_o
  , output logic [SEL_W-1:0]      dst_sel_o
  , output logic [SEL_W-1:0]      s1_sel_o
  , output logic [S2_SEL_W-1:0]   s2_sel_o
  );

  logic [UCODE_W-1:0] ucode;

  // one legal row of the table
  function automatic logic [UCODE_W-1:0] row
    ( input logic                wr
    , input logic [OPCODE_W-1:0] op
    , input logic [FU_W-1:0]     fu
    , input logic                fl
    , input logic [SEL_W-1:0]    dst
    , input logic [SEL_W-1:0]    s1
    , input logic [S2_SEL_W-1:0] s2
    );
    row = {wr, 1'b0, op, fu, fl, dst, s1, s2};
  endfunction

  // addr_i is inst[15:6]
  always_comb begin
    casez (addr_i)
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // shift by immediate
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      10'b00000_?????:
        ucode = row(1'b1, OP_LSL, FU_SHIFT, 1'b1, DST_LO0, S1_LO3, S2_IMM5Z);
      10'b00001_?????:
        ucode = row(1'b1, OP_LSR, FU_SHIFT, 1'b1, DST_LO0, S1_LO3, S2_IMM5Z);

      // add/sub, register or imm3
      10'b0001100_???:
        ucode = row(1'b1, OP_ADD, FU_ALU, 1'b1, DST_LO0, S1_LO3, S2_REG4);
      10'b0001101_???:
        ucode = row(1'b1, OP_SUB, FU_ALU, 1'b1, DST_LO0, S1_LO3, S2_REG4);
      10'b0001110_???:
        ucode = row(1'b1, OP_ADD, FU_ALU, 1'b1, DST_LO0, S1_LO3, S2_IMM3Z);
      10'b0001111_???:
        ucode = row(1'b1, OP_SUB, FU_ALU, 1'b1, DST_LO0, S1_LO3, S2_IMM3Z);

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // mov/cmp/add/sub imm8, rd in bits 10..8
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      10'b00100_?????:
        ucode = row(1'b1, OP_MOV, FU_ALU, 1'b1, DST_HI8, S1_LO0, S2_IMM8Z);
      10'b00101_?????:
        ucode = row(1'b0, OP_CMP, FU_ALU, 1'b1, DST_HI8, S1_LO0, S2_IMM8Z);
      10'b00110_?????:
        ucode = row(1'b1, OP_ADD, FU_ALU, 1'b1, DST_HI8, S1_LO0, S2_IMM8Z);
      10'b00111_?????:
        ucode = row(1'b1, OP_SUB, FU_ALU, 1'b1, DST_HI8, S1_LO0, S2_IMM8Z);

      // register alu group, rd is both dest and source 1
      10'b010000_0000:
        ucode = row(1'b1, OP_AND, FU_ALU, 1'b1, DST_LO0, S1_LO0, S2_REG4);
      10'b010000_0001:
        ucode = row(1'b1, OP_EOR, FU_ALU, 1'b1, DST_LO0, S1_LO0, S2_REG4);
      10'b010000_0010:
        ucode = row(1'b1, OP_LSL, FU_SHIFT, 1'b1, DST_LO0, S1_LO0, S2_REG4);
      10'b010000_0011:
        ucode = row(1'b1, OP_LSR, FU_SHIFT, 1'b1, DST_LO0, S1_LO0, S2_REG4);
      10'b010000_1010:
        ucode = row(1'b0, OP_CMP, FU_ALU, 1'b1, DST_LO0, S1_LO0, S2_REG4);
      10'b010000_1100:
        ucode = row(1'b1, OP_ORR, FU_ALU, 1'b1, DST_LO0, S1_LO0, S2_REG4);

      // hi-register add and mov, no flags
      10'b010001_00??:
        ucode = row(1'b1, OP_ADD, FU_ALU, 1'b0, DST_LO0, S1_LO0, S2_REG4);
      10'b010001_10??:
        ucode = row(1'b1, OP_MOV, FU_ALU, 1'b0, DST_LO0, S1_LO0, S2_REG4);

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // memory, stack and branch
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      10'b01100_?????:
        ucode = row(1'b0, OP_STR, FU_LSU, 1'b0, DST_LO0, S1_LO3, S2_IMM5Z);
      10'b01101_?????:
        ucode = row(1'b1, OP_LDR, FU_LSU, 1'b0, DST_LO0, S1_LO3, S2_IMM5Z);

      // add sp, #imm7 (bit 6 is the top of the immediate)
      10'b101100000_?:
        ucode = row(1'b1, OP_ADD, FU_ALU, 1'b0, DST_SP, S1_SP, S2_IMM7Z);

      10'b11100_?????:
        ucode = row(1'b0, OP_B, FU_BRANCH, 1'b0, DST_LO0, S1_LO0, S2_IMM11S);

      // everything outside the subset
      default:
        ucode = {1'b0, 1'b1, OP_ADD, FU_ALU, 1'b0, DST_LO0, S1_LO0, S2_IMM8Z};
    endcase
  end

  assign {wr_en_o, illegal_o, opcode_o, func_unit_o, set_flags_o,
          dst_sel_o, s1_sel_o, s2_sel_o} = ucode;

endmodule

//--- imm_extend.sv
`timescale 1ns/1ps

module imm_extend
  import thumb_pkg::*;
  ( input  thumb_inst_u           inst_i
  , input  logic [S2_SEL_W-1:0]   s2_sel_i
  , output logic [WORD_SIZE-1:0]  imm_o
  );

  logic [WORD_SIZE-1:0] cand [2**S2_SEL_W];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // zero extended fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign cand[S2_IMM8Z] = {{(WORD_SIZE-8){1'b0}}, inst_i.imm.imm8};

  // add/sub imm3 sits where rm does
  assign cand[S2_IMM3Z] = {{(WORD_SIZE-3){1'b0}}, inst_i.regs.rm};

  // sp offset, low seven bits
  assign cand[S2_IMM7Z] = {{(WORD_SIZE-7){1'b0}}, inst_i[6:0]};

  // shift amount or load/store offset
  assign cand[S2_IMM5Z] = {{(WORD_SIZE-5){1'b0}}, inst_i[10:6]};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sign extended fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign cand[S2_IMM8S] = {{(WORD_SIZE-8){inst_i.imm.imm8[7]}}, inst_i.imm.imm8};

  // branch offset
  assign cand[S2_IMM11S] = {{(WORD_SIZE-11){inst_i[10]}}, inst_i[10:0]};

  assign cand[S2_IMM6S] = {{(WORD_SIZE-6){inst_i[5]}}, inst_i[5:0]};

  // register id as a word, bits 6..3
  assign cand[S2_REG4] = {{(WORD_SIZE-REG_ID_W){1'b0}}, inst_i[6:3]};

  assign imm_o = cand[s2_sel_i];

endmodule

//--- decode.sv
`timescale 1ns/1ps

module decode
  import thumb_pkg::*;
  ( input  logic [WORD_SIZE-1:0] inst_i
  , output logic                 wr_en_o
  , output logic                 illegal_o
  , output logic [OPCODE_W-1:0]  opcode_o
  , output logic [FU_W-1:0]      func_unit_o
  , output logic                 set_flags_o
  , output logic [REG_ID_W-1:0]  dest_id_o
  , output logic [REG_ID_W-1:0]  src1_id_o
  , output logic                 s2_is_reg_o
  , output logic [REG_ID_W-1:0]  s2_reg_id_o
  , output logic [WORD_SIZE-1:0] imm_o
  );

  thumb_inst_u          inst;
  logic [SEL_W-1:0]     dst_sel;
  logic [SEL_W-1:0]     s1_sel;
  logic [S2_SEL_W-1:0]  s2_sel;

  assign inst = inst_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control word lookup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the prefix is inst[15:6]
  microcode_rom u_microcode_rom
    ( .addr_i      ({inst.imm.major, inst.imm.rd_hi, inst.imm.imm8[7:6]})
    , .wr_en_o     (wr_en_o)
    , .illegal_o   (illegal_o)
    , .opcode_o    (opcode_o)
    , .func_unit_o (func_unit_o)
    , .set_flags_o (set_flags_o)
    , .dst_sel_o   (dst_sel)
    , .s1_sel_o    (s1_sel)
    , .s2_sel_o    (s2_sel)
    );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register id selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (dst_sel)
      DST_LO0: dest_id_o = {1'b0, inst.regs.rd};
      DST_HI8: dest_id_o = {1'b0, inst.imm.rd_hi};
      DST_SP:  dest_id_o = SP_ID;
      default: dest_id_o = LR_ID;
    endcase
  end

  always_comb begin
    case (s1_sel)
      S1_LO3:  src1_id_o = {1'b0, inst.regs.rn};
      S1_LO0:  src1_id_o = {1'b0, inst.regs.rd};
      S1_SP:   src1_id_o = SP_ID;
      default: src1_id_o = LR_ID;
    endcase
  end

  // source 2 is either a register read or an extended field
  assign s2_is_reg_o = (s2_sel == S2_REG4);
  assign s2_reg_id_o = inst_i[6:3];

  imm_extend u_imm_extend
    ( .inst_i   (inst)
    , .s2_sel_i (s2_sel)
    , .imm_o    (imm_o)
    );

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file
  import thumb_pkg::*;
  ( input  logic                 clk_i
  , input  logic                 arst_n_i
  , input  logic                 wb_en_i
  , input  logic [REG_ID_W-1:0]  wb_id_i
  , input  logic [WORD_SIZE-1:0] wb_data_i
  , input  logic [REG_ID_W-1:0]  rd_a_id_i
  , input  logic [REG_ID_W-1:0]  rd_b_id_i
  , output logic [WORD_SIZE-1:0] rd_a_data_o
  , output logic [WORD_SIZE-1:0] rd_b_data_o
  );

  logic [WORD_SIZE-1:0] regs [NUM_REG];

  // array read with bypass of the write in flight
  function automatic logic [WORD_SIZE-1:0] fwd_read
    ( input logic [REG_ID_W-1:0] id
    );
    if (wb_en_i && (wb_id_i == id)) begin
      fwd_read = wb_data_i;
    end else begin
      fwd_read = regs[id];
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write port and registered reads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_REG; i++) begin
        regs[i] <= '0;
      end
      rd_a_data_o <= '0;
      rd_b_data_o <= '0;
    end else begin
      if (wb_en_i) begin
        regs[wb_id_i] <= wb_data_i;
      end
      rd_a_data_o <= fwd_read(rd_a_id_i);
      rd_b_data_o <= fwd_read(rd_b_id_i);
    end
  end

endmodule

//--- thumb_front_end.sv
`timescale 1ns/1ps

module thumb_front_end
  import thumb_pkg::*;
  ( input  logic                 clk_i
  , input  logic                 arst_n_i
  , input  logic                 inst_valid_i
  , input  logic [WORD_SIZE-1:0] inst_i
  , input  logic                 wb_en_i
  , input  logic [REG_ID_W-1:0]  wb_id_i
  , input  logic [WORD_SIZE-1:0] wb_data_i
  , output logic                 out_valid_o
  , output logic                 illegal_o
  , output logic                 wr_en_o
  , output logic [OPCODE_W-1:0]  opcode_o
  , output logic [FU_W-1:0]      func_unit_o
  , output logic                 set_flags_o
  , output logic [REG_ID_W-1:0]  dest_id_o
  , output logic [REG_ID_W-1:0]  src1_id_o
  , output logic [WORD_SIZE-1:0] src1_data_o
  , output logic [WORD_SIZE-1:0] src2_data_o
  );

  // decode outputs
  logic                 dec_wr_en, dec_illegal, dec_set_flags, dec_s2_is_reg;
  logic [OPCODE_W-1:0]  dec_opcode;
  logic [FU_W-1:0]      dec_fu;
  logic [REG_ID_W-1:0]  dec_dest_id, dec_src1_id, dec_s2_reg_id;
  logic [WORD_SIZE-1:0] dec_imm;

  // stage 1
  logic                 valid_s1, wr_en_s1, illegal_s1, set_flags_s1, s2_is_reg_s1;
  logic [OPCODE_W-1:0]  opcode_s1;
  logic [FU_W-1:0]      fu_s1;
  logic [REG_ID_W-1:0]  dest_id_s1, src1_id_s1, s2_reg_id_s1;
  logic [WORD_SIZE-1:0] imm_s1;

  // stage 2 operand side
  logic                 s2_is_reg_s2;
  logic [WORD_SIZE-1:0] imm_s2, rd_a_data, rd_b_data, src2_live;
  logic [WORD_SIZE-1:0] src1_hold, src2_hold;

  decode u_decode
    ( .inst_i      (inst_i)
    , .wr_en_o     (dec_wr_en)
    , .illegal_o   (dec_illegal)
    , .opcode_o    (dec_opcode)
    , .func_unit_o (dec_fu)
    , .set_flags_o (dec_set_flags)
    , .dest_id_o   (dec_dest_id)
    , .src1_id_o   (dec_src1_id)
    , .s2_is_reg_o (dec_s2_is_reg)
    , .s2_reg_id_o (dec_s2_reg_id)
    , .imm_o       (dec_imm)
    );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // valid pipeline and stage 2 control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_s1    <= 1'b0;
      out_valid_o <= 1'b0;
      wr_en_o     <= 1'b0;
      illegal_o   <= 1'b0;
    end else begin
      valid_s1    <= inst_valid_i;
      out_valid_o <= valid_s1;
      if (valid_s1) begin
        wr_en_o   <= wr_en_s1;
        illegal_o <= illegal_s1;
      end
    end
  end

  // stage 1 payload, only loaded with a new instruction
  always_ff @(posedge clk_i) begin
    if (inst_valid_i) begin
      wr_en_s1     <= dec_wr_en;
      illegal_s1   <= dec_illegal;
      opcode_s1    <= dec_opcode;
      fu_s1        <= dec_fu;
      set_flags_s1 <= dec_set_flags;
      dest_id_s1   <= dec_dest_id;
      src1_id_s1   <= dec_src1_id;
      s2_is_reg_s1 <= dec_s2_is_reg;
      s2_reg_id_s1 <= dec_s2_reg_id;
      imm_s1       <= dec_imm;
    end
  end

  // stage 2 payload
  always_ff @(posedge clk_i) begin
    if (valid_s1) begin
      opcode_o     <= opcode_s1;
      func_unit_o  <= fu_s1;
      set_flags_o  <= set_flags_s1;
      dest_id_o    <= dest_id_s1;
      src1_id_o    <= src1_id_s1;
      s2_is_reg_s2 <= s2_is_reg_s1;
      imm_s2       <= imm_s1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand read
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  register_file u_register_file
    ( .clk_i       (clk_i)
    , .arst_n_i    (arst_n_i)
    , .wb_en_i     (wb_en_i)
    , .wb_id_i     (wb_id_i)
    , .wb_data_i   (wb_data_i)
    , .rd_a_id_i   (src1_id_s1)
    , .rd_b_id_i   (s2_reg_id_s1)
    , .rd_a_data_o (rd_a_data)
    , .rd_b_data_o (rd_b_data)
    );

  assign src2_live = s2_is_reg_s2 ? rd_b_data : imm_s2;

  // keep last operands while idle, the file keeps reading every cycle
  always_ff @(posedge clk_i) begin
    if (out_valid_o) begin
      src1_hold <= rd_a_data;
      src2_hold <= src2_live;
    end
  end

  assign src1_data_o = out_valid_o ? rd_a_data : src1_hold;
  assign src2_data_o = out_valid_o ? src2_live : src2_hold;

endmodule

//--- thumb_front_end_sva.sv
`timescale 1ns/1ps

module thumb_front_end_sva
  ( input logic clk_i
  , input logic arst_n_i
  , input logic inst_valid_i
  , input logic out_valid_o
  , input logic illegal_o
  , input logic wr_en_o
  );

  int unsigned fail_cnt = 0;

  // two register stages between the valid strobes
  property p_valid_latency;
    @(posedge clk_i) disable iff (!arst_n_i)
      $past(arst_n_i, 2) |-> (out_valid_o == $past(inst_valid_i, 2));
  endproperty

  property p_no_write_when_illegal;
    @(posedge clk_i) disable iff (!arst_n_i)
      illegal_o |-> !wr_en_o;
  endproperty

  property p_idle_in_reset;
    @(posedge clk_i) !arst_n_i |-> !out_valid_o;
  endproperty

  a_valid_latency: assert property (p_valid_latency)
    else begin
      fail_cnt++;
      $error("out_valid_o is not inst_valid_i delayed by two cycles");
    end

  a_no_write_when_illegal: assert property (p_no_write_when_illegal)
    else begin
      fail_cnt++;
      $error("wr_en_o high together with illegal_o");
    end

  a_idle_in_reset: assert property (p_idle_in_reset)
    else begin
      fail_cnt++;
      $error("out_valid_o high during reset");
    end

endmodule

bind thumb_front_end thumb_front_end_sva u_thumb_front_end_sva
  ( .clk_i        (clk_i)
  , .arst_n_i     (arst_n_i)
  , .inst_valid_i (inst_valid_i)
  , .out_valid_o  (out_valid_o)
  , .illegal_o    (illegal_o)
  , .wr_en_o      (wr_en_o)
  );

//--- thumb_front_end_tb.sv
`timescale 1ns/1ps

module thumb_front_end_tb
  import thumb_pkg::*;
  ();

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DLY    = 5;
  localparam int RESET_CYCLES = 3;
  localparam int MAX_ROWS     = 32;
  // reset, preload, table, drain and some slack
  localparam int RUN_CYCLES   = RESET_CYCLES + NUM_REG + MAX_ROWS + 8 + 20;

  logic                 clk_i, arst_n_i, inst_valid_i, wb_en_i;
  logic [WORD_SIZE-1:0] inst_i, wb_data_i;
  logic [REG_ID_W-1:0]  wb_id_i;
  logic                 out_valid_o, illegal_o, wr_en_o, set_flags_o;
  logic [OPCODE_W-1:0]  opcode_o;
  logic [FU_W-1:0]      func_unit_o;
  logic [REG_ID_W-1:0]  dest_id_o, src1_id_o;
  logic [WORD_SIZE-1:0] src1_data_o, src2_data_o;

  typedef struct packed {
    logic [WORD_SIZE-1:0] inst;
    logic                 illegal;
    logic                 wr_en;
    logic [OPCODE_W-1:0]  opcode;
    logic [FU_W-1:0]      fu;
    logic                 set_flags;
    logic [REG_ID_W-1:0]  dest_id;
    logic [REG_ID_W-1:0]  src1_id;
    logic                 s2_is_reg;
    // immediate value, or the register id for a register operand
    logic [WORD_SIZE-1:0] s2_val;
    logic                 wb_en;
    logic [REG_ID_W-1:0]  wb_id;
    logic [WORD_SIZE-1:0] wb_data;
  } row_t;

  row_t                 rows     [MAX_ROWS];
  logic [WORD_SIZE-1:0] exp_src1 [MAX_ROWS];
  logic [WORD_SIZE-1:0] exp_src2 [MAX_ROWS];
  logic [WORD_SIZE-1:0] model    [NUM_REG];
  int                   num_rows, err_cnt, check_cnt, seed;

  thumb_front_end u_thumb_front_end
    ( .clk_i        (clk_i)
    , .arst_n_i     (arst_n_i)
    , .inst_valid_i (inst_valid_i)
    , .inst_i       (inst_i)
    , .wb_en_i      (wb_en_i)
    , .wb_id_i      (wb_id_i)
    , .wb_data_i    (wb_data_i)
    , .out_valid_o  (out_valid_o)
    , .illegal_o    (illegal_o)
    , .wr_en_o      (wr_en_o)
    , .opcode_o     (opcode_o)
    , .func_unit_o  (func_unit_o)
    , .set_flags_o  (set_flags_o)
    , .dest_id_o    (dest_id_o)
    , .src1_id_o    (src1_id_o)
    , .src1_data_o  (src1_data_o)
    , .src2_data_o  (src2_data_o)
    );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("run timed out after %0d cycles before all rows were checked", RUN_CYCLES);
    $display("Checks failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_opcode(input string name, input logic [OPCODE_W-1:0] got,
                              input logic [OPCODE_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_fu(input string name, input logic [FU_W-1:0] got,
                          input logic [FU_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input logic [REG_ID_W-1:0] got,
                          input logic [REG_ID_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [WORD_SIZE-1:0] got,
                            input logic [WORD_SIZE-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic add_row(input logic [WORD_SIZE-1:0] inst, input logic wr,
                         input logic [OPCODE_W-1:0] op, input logic [FU_W-1:0] fu,
                         input logic fl, input logic [REG_ID_W-1:0] dst,
                         input logic [REG_ID_W-1:0] s1, input logic s2_reg,
                         input logic [WORD_SIZE-1:0] s2_val);
    rows[num_rows] = '{inst, 1'b0, wr, op, fu, fl, dst, s1, s2_reg, s2_val,
                       1'b0, '0, '0};
    num_rows++;
  endtask

  task automatic add_illegal(input logic [WORD_SIZE-1:0] inst);
    rows[num_rows]         = '0;
    rows[num_rows].inst    = inst;
    rows[num_rows].illegal = 1'b1;
    num_rows++;
  endtask

  // write-back issued on the read cycle of the last row added
  task automatic add_wb(input logic [REG_ID_W-1:0] id, input logic [WORD_SIZE-1:0] data);
    rows[num_rows-1].wb_en   = 1'b1;
    rows[num_rows-1].wb_id   = id;
    rows[num_rows-1].wb_data = data;
  endtask

  task automatic build_table();
    // rows 0 and 1 run before the preload and read cleared registers
    add_row(16'h44F7, 1'b1, OP_ADD, FU_ALU, 1'b0, 4'd7, 4'd7, 1'b1, 16'd14);
    add_row(16'h46EA, 1'b1, OP_MOV, FU_ALU, 1'b0, 4'd2, 4'd2, 1'b1, 16'd13);
    add_row(16'h23A5, 1'b1, OP_MOV, FU_ALU, 1'b1, 4'd3, 4'd5, 1'b0, 16'h00A5);
    add_row(16'h2E7F, 1'b0, OP_CMP, FU_ALU, 1'b1, 4'd6, 4'd7, 1'b0, 16'h007F);
    add_row(16'h31FF, 1'b1, OP_ADD, FU_ALU, 1'b1, 4'd1, 4'd7, 1'b0, 16'h00FF);
    add_row(16'h1D95, 1'b1, OP_ADD, FU_ALU, 1'b1, 4'd5, 4'd2, 1'b0, 16'h0006);
    add_row(16'h18F0, 1'b1, OP_ADD, FU_ALU, 1'b1, 4'd0, 4'd6, 1'b1, 16'd14);
    add_wb(4'd6, 16'h1234);
    add_row(16'h1B4F, 1'b1, OP_SUB, FU_ALU, 1'b1, 4'd7, 4'd1, 1'b1, 16'd9);
    add_wb(4'd9, 16'hBEEF);
    add_row(16'h055C, 1'b1, OP_LSL, FU_SHIFT, 1'b1, 4'd4, 4'd3, 1'b0, 16'h0015);
    add_row(16'h401E, 1'b1, OP_AND, FU_ALU, 1'b1, 4'd6, 4'd6, 1'b1, 16'd3);
    add_row(16'h4315, 1'b1, OP_ORR, FU_ALU, 1'b1, 4'd5, 4'd5, 1'b1, 16'd2);
    add_row(16'h42A0, 1'b0, OP_CMP, FU_ALU, 1'b1, 4'd0, 4'd0, 1'b1, 16'd4);
    add_row(16'h6D9F, 1'b1, OP_LDR, FU_LSU, 1'b0, 4'd7, 4'd3, 1'b0, 16'h0016);
    add_row(16'h6170, 1'b0, OP_STR, FU_LSU, 1'b0, 4'd0, 4'd6, 1'b0, 16'h0005);
    add_row(16'hB059, 1'b1, OP_ADD, FU_ALU, 1'b0, SP_ID, SP_ID, 1'b0, 16'h0059);
    add_row(16'hE7FC, 1'b0, OP_B, FU_BRANCH, 1'b0, 4'd4, 4'd4, 1'b0, 16'hFFFC);
    add_row(16'h4468, 1'b1, OP_ADD, FU_ALU, 1'b0, 4'd0, 4'd0, 1'b1, 16'd13);
    add_wb(SP_ID, 16'h0F0F);
    add_illegal(16'hDF00);
    add_illegal(16'hB500);
    add_illegal(16'h470D);
    add_row(16'h2001, 1'b1, OP_MOV, FU_ALU, 1'b1, 4'd0, 4'd1, 1'b0, 16'h0001);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // drive, predict and check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic next_slot();
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic set_wb(input logic en, input logic [REG_ID_W-1:0] id,
                        input logic [WORD_SIZE-1:0] data);
    wb_en_i   = en;
    wb_id_i   = id;
    wb_data_i = data;
  endtask

  task automatic preload();
    logic [WORD_SIZE-1:0] val;
    for (int i = 0; i < NUM_REG; i++) begin
      val = $random(seed);
      next_slot();
      set_wb(1'b1, REG_ID_W'(i), val);
      model[i] = val;
    end
    next_slot();
    wb_en_i = 1'b0;
  endtask

  task automatic predict_rows(input int first, input int last);
    for (int r = first; r <= last; r++) begin
      // a write on the read cycle is seen by that read
      if (rows[r].wb_en) begin
        model[rows[r].wb_id] = rows[r].wb_data;
      end
      exp_src1[r] = model[rows[r].src1_id];
      exp_src2[r] = rows[r].s2_is_reg ? model[rows[r].s2_val[REG_ID_W-1:0]]
                                      : rows[r].s2_val;
    end
  endtask

  task automatic check_row(input int r);
    int errs_before;
    errs_before = err_cnt;
    check_flag("illegal_o", illegal_o, rows[r].illegal);
    check_flag("wr_en_o", wr_en_o, rows[r].wr_en);
    // only the two flags are defined for an illegal encoding
    if (!rows[r].illegal) begin
      check_opcode("opcode_o", opcode_o, rows[r].opcode);
      check_fu("func_unit_o", func_unit_o, rows[r].fu);
      check_flag("set_flags_o", set_flags_o, rows[r].set_flags);
      check_id("dest_id_o", dest_id_o, rows[r].dest_id);
      check_id("src1_id_o", src1_id_o, rows[r].src1_id);
      check_word("src1_data_o", src1_data_o, exp_src1[r]);
      check_word("src2_data_o", src2_data_o, exp_src2[r]);
    end
    $display("row %0d inst 0x%h %s", r, rows[r].inst,
             (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  task automatic run_rows(input int first, input int last);
    int idx;
    predict_rows(first, last);
    idx = first;
    fork
      begin
        for (int r = first; r <= last; r++) begin
          next_slot();
          inst_valid_i = 1'b1;
          inst_i       = rows[r].inst;
          // previous row is on its read cycle now
          if (r > first) begin
            set_wb(rows[r-1].wb_en, rows[r-1].wb_id, rows[r-1].wb_data);
          end
        end
        next_slot();
        inst_valid_i = 1'b0;
        set_wb(rows[last].wb_en, rows[last].wb_id, rows[last].wb_data);
        next_slot();
        wb_en_i = 1'b0;
      end
      begin
        while (idx <= last) begin
          @(negedge clk_i);
          if (out_valid_o) begin
            check_row(idx);
            idx++;
          end else if (idx > first) begin
            err_cnt++;
            $display("out_valid_o dropped in the middle of back-to-back issue at row %0d", idx);
          end
        end
      end
    join
  endtask

  initial begin
    seed         = 83;
    err_cnt      = 0;
    check_cnt    = 0;
    num_rows     = 0;
    arst_n_i     = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    set_wb(1'b0, '0, '0);
    for (int i = 0; i < NUM_REG; i++) begin
      model[i] = '0;
    end
    build_table();
    #1 arst_n_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY arst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("wr_en_o", wr_en_o, 1'b0);
    run_rows(0, 1);
    preload();
    run_rows(2, num_rows - 1);
    err_cnt += u_thumb_front_end.u_thumb_front_end_sva.fail_cnt;
    $display("rows %0d, checks %0d, errors %0d", num_rows, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- thumb_front_end.f
thumb_pkg.sv
microcode_rom.sv
imm_extend.sv
decode.sv
register_file.sv
thumb_front_end.sv
thumb_front_end_sva.sv
thumb_front_end_tb.sv
